// File: common/proc_pkg.sv
`default_nettype none

package proc_pkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////
    localparam int XLEN     = 32;
    localparam int NUM_REGS = 8;
    localparam int REG_AW   = 3;
    localparam int IMM_W    = 16;
    localparam int OP_W     = 4;

    // Fetch address increment
    localparam logic [XLEN-1:0] PC_STEP = 32'd4;

    // Opcodes
    localparam logic [OP_W-1:0] OP_NOP   = 4'd0;
    localparam logic [OP_W-1:0] OP_ADD   = 4'd1;
    localparam logic [OP_W-1:0] OP_SUB   = 4'd2;
    localparam logic [OP_W-1:0] OP_AND   = 4'd3;
    localparam logic [OP_W-1:0] OP_OR    = 4'd4;
    localparam logic [OP_W-1:0] OP_XOR   = 4'd5;
    localparam logic [OP_W-1:0] OP_ADDI  = 4'd6;
    localparam logic [OP_W-1:0] OP_STORE = 4'd7;

    // Stage payloads: op, rd, a, b, store data / op, rd, result, store data
    localparam int DE_PAYLOAD_W = OP_W + REG_AW + 3 * XLEN;
    localparam int EC_PAYLOAD_W = OP_W + REG_AW + 2 * XLEN;

    //////////////////////////////////////////////////
    // Instruction word, register and immediate views
    //////////////////////////////////////////////////
    typedef union packed {
        struct packed {
            logic [OP_W-1:0]                    opcode;
            logic [REG_AW-1:0]                  rd;
            logic [REG_AW-1:0]                  rs1;
            logic [REG_AW-1:0]                  rs2;
            logic [XLEN-OP_W-3*REG_AW-1:0]      unused;
        } r;
        struct packed {
            logic [OP_W-1:0]                    opcode;
            logic [REG_AW-1:0]                  rd;     // Store source for OP_STORE
            logic [REG_AW-1:0]                  rs1;
            logic [XLEN-OP_W-2*REG_AW-IMM_W-1:0] spare;
            logic [IMM_W-1:0]                   imm;
        } i;
    } insn_u;

endpackage

`default_nettype wire

// File: design/pipe_buffer.sv
`default_nettype none

module pipe_buffer #(
    parameter int WIDTH = 32
) (
    input  logic             clk_i,
    input  logic             reset_i,
    // Upstream side
    input  logic [WIDTH-1:0] data_i,
    input  logic             valid_i,
    output logic             ready_o,
    // Downstream side
    output logic [WIDTH-1:0] data_o,
    output logic             valid_o,
    input  logic             ready_i
);
    logic [WIDTH-1:0] data_q;
    logic             valid_q;
    logic             accept;

    // Room when empty, or when the held entry leaves this cycle
    assign ready_o = ~valid_q | ready_i;
    assign accept  = valid_i & ready_o;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else if (accept) begin
            valid_q <= 1'b1;
        end else if (ready_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            data_q <= data_i;
        end
    end

    assign data_o  = data_q;
    assign valid_o = valid_q;

endmodule

`default_nettype wire

// File: design/register_file.sv
`default_nettype none

module register_file import proc_pkg::*; (
    input  logic              clk_i,
    input  logic              reset_i,
    input  logic [REG_AW-1:0] rs1_addr_i,
    input  logic [REG_AW-1:0] rs2_addr_i,
    output logic [XLEN-1:0]   rs1_data_o,
    output logic [XLEN-1:0]   rs2_data_o,
    input  logic              we_i,
    input  logic [REG_AW-1:0] wr_addr_i,
    input  logic [XLEN-1:0]   wr_data_i
);
    logic [NUM_REGS-1:0][XLEN-1:0] regs_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            regs_q <= '0;
        end else if (we_i && wr_addr_i != '0) begin
            regs_q[wr_addr_i] <= wr_data_i;
        end
    end

    // r0 reads zero, a same-cycle write is passed straight through
    assign rs1_data_o = (rs1_addr_i == '0)                    ? '0        :
                        (we_i && wr_addr_i == rs1_addr_i)     ? wr_data_i :
                                                                regs_q[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0)                    ? '0        :
                        (we_i && wr_addr_i == rs2_addr_i)     ? wr_data_i :
                                                                regs_q[rs2_addr_i];

endmodule

`default_nettype wire

// File: fetch/fetch_unit.sv
`default_nettype none

module fetch_unit import proc_pkg::*; (
    input  logic            clk_i,
    input  logic            reset_i,
    // Wishbone classic read master
    output logic            ibus_cyc_o,
    output logic            ibus_stb_o,
    output logic [XLEN-1:0] ibus_adr_o,
    input  logic [XLEN-1:0] ibus_dat_i,
    input  logic            ibus_ack_i,
    // Towards the fetch/decode buffer
    output logic [XLEN-1:0] insn_o,
    output logic            valid_o,
    input  logic            ready_i
);
    logic [XLEN-1:0] pc_q;
    logic            cyc_q;
    logic            ack_seen;

    assign ack_seen = cyc_q & ibus_ack_i;

    // The buffer has room from the request until the ack
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pc_q  <= '0;
            cyc_q <= 1'b0;
        end else begin
            if (ack_seen) begin
                cyc_q <= 1'b0;
                pc_q  <= pc_q + PC_STEP;
            end else if (!cyc_q && ready_i) begin
                cyc_q <= 1'b1;
            end
        end
    end

    assign ibus_cyc_o = cyc_q;
    assign ibus_stb_o = cyc_q;
    assign ibus_adr_o = pc_q;

    assign valid_o = ack_seen;
    assign insn_o  = ibus_dat_i;

endmodule

`default_nettype wire

// File: decode/decode_stage.sv
`default_nettype none

module decode_stage import proc_pkg::*; (
    input  logic              clk_i,
    input  logic              reset_i,
    // From the fetch/decode buffer
    input  insn_u             insn_i,
    input  logic              valid_i,
    output logic              ready_o,
    // Register file read ports
    output logic [REG_AW-1:0] rs1_addr_o,
    output logic [REG_AW-1:0] rs2_addr_o,
    input  logic [XLEN-1:0]   rs1_data_i,
    input  logic [XLEN-1:0]   rs2_data_i,
    // Towards the decode/execute buffer
    output logic [OP_W-1:0]   op_o,
    output logic [REG_AW-1:0] rd_o,
    output logic [XLEN-1:0]   a_o,
    output logic [XLEN-1:0]   b_o,
    output logic              valid_o,
    input  logic              ready_i,
    // Scoreboard release from commit
    input  logic              release_i,
    input  logic [REG_AW-1:0] release_addr_i
);
    logic [OP_W-1:0]     op;
    logic                is_reg_alu;
    logic                is_addi;
    logic                is_store;
    logic                writes_rd;
    logic                use_rs1;
    logic                use_rs2;
    logic [XLEN-1:0]     imm_ext;
    logic [NUM_REGS-1:0] busy_q;
    logic [NUM_REGS-1:0] busy_now;
    logic [NUM_REGS-1:0] clr_mask;
    logic [NUM_REGS-1:0] set_mask;
    logic                hazard;
    logic                issue;

    assign op         = insn_i.r.opcode;
    assign is_reg_alu = op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};
    assign is_addi    = (op == OP_ADDI);
    assign is_store   = (op == OP_STORE);
    assign writes_rd  = is_reg_alu | is_addi;
    assign use_rs1    = is_reg_alu | is_addi | is_store;
    assign use_rs2    = is_reg_alu | is_store;

    // Stores read their data register through the second port
    assign rs1_addr_o = insn_i.r.rs1;
    assign rs2_addr_o = is_store ? insn_i.i.rd : insn_i.r.rs2;
    assign imm_ext    = {{(XLEN-IMM_W){insn_i.i.imm[IMM_W-1]}}, insn_i.i.imm};

    assign op_o = op;
    assign rd_o = insn_i.r.rd;
    assign a_o  = rs1_data_i;
    assign b_o  = (is_addi | is_store) ? imm_ext : rs2_data_i;

    //////////////////////////////////////////////////
    // Scoreboard
    //////////////////////////////////////////////////
    // A release in this cycle already counts, the write-through read covers it
    assign clr_mask = release_i ? (NUM_REGS'(1) << release_addr_i) : '0;
    assign busy_now = busy_q & ~clr_mask;

    // Also wait on rd so an older write cannot clear a newer busy bit
    assign hazard = (use_rs1 & busy_now[rs1_addr_o])
                  | (use_rs2 & busy_now[rs2_addr_o])
                  | (writes_rd & busy_now[insn_i.r.rd]);

    assign valid_o = valid_i & ~hazard;
    assign ready_o = ready_i & ~hazard;
    assign issue   = valid_o & ready_i;

    assign set_mask = (issue & writes_rd) ? (NUM_REGS'(1) << insn_i.r.rd) : '0;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy_q <= '0;
        end else begin
            busy_q <= (busy_now | set_mask) & ~NUM_REGS'(1);
        end
    end

endmodule

`default_nettype wire

// File: execute/execute_stage.sv
`default_nettype none

module execute_stage import proc_pkg::*; (
    input  logic [OP_W-1:0]   op_i,
    input  logic [REG_AW-1:0] rd_i,
    input  logic [XLEN-1:0]   a_i,
    input  logic [XLEN-1:0]   b_i,
    input  logic [XLEN-1:0]   store_data_i,
    output logic [OP_W-1:0]   op_o,
    output logic [REG_AW-1:0] rd_o,
    output logic [XLEN-1:0]   result_o,
    output logic [XLEN-1:0]   store_data_o
);
    // ALU, the store address is rs1 plus the immediate in b
    always_comb begin
        case (op_i)
            OP_ADD, OP_ADDI, OP_STORE: result_o = a_i + b_i;
            OP_SUB:                    result_o = a_i - b_i;
            OP_AND:                    result_o = a_i & b_i;
            OP_OR:                     result_o = a_i | b_i;
            OP_XOR:                    result_o = a_i ^ b_i;
            default:                   result_o = '0;
        endcase
    end

    assign op_o         = op_i;
    assign rd_o         = rd_i;
    assign store_data_o = store_data_i;

endmodule

`default_nettype wire

// File: commit/commit_stage.sv
`default_nettype none

module commit_stage import proc_pkg::*; (
    input  logic              clk_i,
    input  logic              reset_i,
    // From the execute/commit buffer
    input  logic [OP_W-1:0]   op_i,
    input  logic [REG_AW-1:0] rd_i,
    input  logic [XLEN-1:0]   result_i,
    input  logic [XLEN-1:0]   store_data_i,
    input  logic              valid_i,
    output logic              ready_o,
    // Wishbone classic write master
    output logic              dbus_cyc_o,
    output logic              dbus_stb_o,
    output logic              dbus_we_o,
    output logic [XLEN-1:0]   dbus_adr_o,
    output logic [XLEN-1:0]   dbus_dat_o,
    input  logic              dbus_ack_i,
    // Register writeback, also the scoreboard release
    output logic              we_o,
    output logic [REG_AW-1:0] wr_addr_o,
    output logic [XLEN-1:0]   wr_data_o
);
    logic            cyc_q;
    logic [XLEN-1:0] adr_q;
    logic [XLEN-1:0] dat_q;
    logic            accept;
    logic            is_wb;
    logic            is_store;

    // Busy for the whole store bus cycle
    assign ready_o  = ~cyc_q;
    assign accept   = valid_i & ready_o;
    assign is_wb    = op_i inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI};
    assign is_store = (op_i == OP_STORE);

    // ALU results retire in the accept cycle
    assign we_o      = accept & is_wb;
    assign wr_addr_o = rd_i;
    assign wr_data_o = result_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            cyc_q <= 1'b0;
        end else if (cyc_q && dbus_ack_i) begin
            cyc_q <= 1'b0;
        end else if (accept && is_store) begin
            cyc_q <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept && is_store) begin
            adr_q <= result_i;
            dat_q <= store_data_i;
        end
    end

    assign dbus_cyc_o = cyc_q;
    assign dbus_stb_o = cyc_q;
    assign dbus_we_o  = cyc_q;
    assign dbus_adr_o = adr_q;
    assign dbus_dat_o = dat_q;

endmodule

`default_nettype wire

// File: design/proc_top.sv
`default_nettype none

module proc_top import proc_pkg::*; (
    input  logic            clk_i,
    input  logic            reset_i,
    // Instruction bus
    output logic            ibus_cyc_o,
    output logic            ibus_stb_o,
    output logic [XLEN-1:0] ibus_adr_o,
    input  logic [XLEN-1:0] ibus_dat_i,
    input  logic            ibus_ack_i,
    // Data bus
    output logic            dbus_cyc_o,
    output logic            dbus_stb_o,
    output logic            dbus_we_o,
    output logic [XLEN-1:0] dbus_adr_o,
    output logic [XLEN-1:0] dbus_dat_o,
    input  logic            dbus_ack_i
);
    //////////////////////////////////////////////////
    // Fetch and fetch/decode buffer
    //////////////////////////////////////////////////
    logic [XLEN-1:0] if_insn;
    logic            if_valid;
    logic            if_ready;
    insn_u           fd_insn;
    logic            fd_valid;
    logic            fd_ready;

    fetch_unit u_fetch (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .ibus_cyc_o (ibus_cyc_o),
        .ibus_stb_o (ibus_stb_o),
        .ibus_adr_o (ibus_adr_o),
        .ibus_dat_i (ibus_dat_i),
        .ibus_ack_i (ibus_ack_i),
        .insn_o     (if_insn),
        .valid_o    (if_valid),
        .ready_i    (if_ready)
    );

    pipe_buffer #(.WIDTH(XLEN)) u_fd_buf (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .data_i  (if_insn),
        .valid_i (if_valid),
        .ready_o (if_ready),
        .data_o  (fd_insn),
        .valid_o (fd_valid),
        .ready_i (fd_ready)
    );

    //////////////////////////////////////////////////
    // Decode, register file and decode/execute buffer
    //////////////////////////////////////////////////
    logic [REG_AW-1:0]       rf_rs1_addr;
    logic [REG_AW-1:0]       rf_rs2_addr;
    logic [XLEN-1:0]         rf_rs1_data;
    logic [XLEN-1:0]         rf_rs2_data;
    logic                    wb_we;
    logic [REG_AW-1:0]       wb_addr;
    logic [XLEN-1:0]         wb_data;
    logic [OP_W-1:0]         id_op;
    logic [REG_AW-1:0]       id_rd;
    logic [XLEN-1:0]         id_a;
    logic [XLEN-1:0]         id_b;
    logic                    id_valid;
    logic                    id_ready;
    logic [DE_PAYLOAD_W-1:0] de_payload_in;
    logic [DE_PAYLOAD_W-1:0] de_payload;
    logic                    de_valid;
    logic                    de_ready;

    register_file u_regs (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .rs1_addr_i (rf_rs1_addr),
        .rs2_addr_i (rf_rs2_addr),
        .rs1_data_o (rf_rs1_data),
        .rs2_data_o (rf_rs2_data),
        .we_i       (wb_we),
        .wr_addr_i  (wb_addr),
        .wr_data_i  (wb_data)
    );

    decode_stage u_decode (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .insn_i         (fd_insn),
        .valid_i        (fd_valid),
        .ready_o        (fd_ready),
        .rs1_addr_o     (rf_rs1_addr),
        .rs2_addr_o     (rf_rs2_addr),
        .rs1_data_i     (rf_rs1_data),
        .rs2_data_i     (rf_rs2_data),
        .op_o           (id_op),
        .rd_o           (id_rd),
        .a_o            (id_a),
        .b_o            (id_b),
        .valid_o        (id_valid),
        .ready_i        (id_ready),
        .release_i      (wb_we),
        .release_addr_i (wb_addr)
    );

    // Second read port carries the store value for OP_STORE
    assign de_payload_in = {id_op, id_rd, id_a, id_b, rf_rs2_data};

    pipe_buffer #(.WIDTH(DE_PAYLOAD_W)) u_de_buf (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .data_i  (de_payload_in),
        .valid_i (id_valid),
        .ready_o (id_ready),
        .data_o  (de_payload),
        .valid_o (de_valid),
        .ready_i (de_ready)
    );

    //////////////////////////////////////////////////
    // Execute and execute/commit buffer
    //////////////////////////////////////////////////
    logic [OP_W-1:0]         ex_op;
    logic [REG_AW-1:0]       ex_rd;
    logic [XLEN-1:0]         ex_a;
    logic [XLEN-1:0]         ex_b;
    logic [XLEN-1:0]         ex_store_data;
    logic [EC_PAYLOAD_W-1:0] ec_payload_in;
    logic [EC_PAYLOAD_W-1:0] ec_payload;
    logic                    ec_valid;
    logic                    ec_ready;

    assign {ex_op, ex_rd, ex_a, ex_b, ex_store_data} = de_payload;

    execute_stage u_execute (
        .op_i         (ex_op),
        .rd_i         (ex_rd),
        .a_i          (ex_a),
        .b_i          (ex_b),
        .store_data_i (ex_store_data),
        .op_o         (ec_payload_in[EC_PAYLOAD_W-1 -: OP_W]),
        .rd_o         (ec_payload_in[2*XLEN +: REG_AW]),
        .result_o     (ec_payload_in[XLEN +: XLEN]),
        .store_data_o (ec_payload_in[0 +: XLEN])
    );

    pipe_buffer #(.WIDTH(EC_PAYLOAD_W)) u_ec_buf (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .data_i  (ec_payload_in),
        .valid_i (de_valid),
        .ready_o (de_ready),
        .data_o  (ec_payload),
        .valid_o (ec_valid),
        .ready_i (ec_ready)
    );

    //////////////////////////////////////////////////
    // Commit
    //////////////////////////////////////////////////
    commit_stage u_commit (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .op_i         (ec_payload[EC_PAYLOAD_W-1 -: OP_W]),
        .rd_i         (ec_payload[2*XLEN +: REG_AW]),
        .result_i     (ec_payload[XLEN +: XLEN]),
        .store_data_i (ec_payload[0 +: XLEN]),
        .valid_i      (ec_valid),
        .ready_o      (ec_ready),
        .dbus_cyc_o   (dbus_cyc_o),
        .dbus_stb_o   (dbus_stb_o),
        .dbus_we_o    (dbus_we_o),
        .dbus_adr_o   (dbus_adr_o),
        .dbus_dat_o   (dbus_dat_o),
        .dbus_ack_i   (dbus_ack_i),
        .we_o         (wb_we),
        .wr_addr_o    (wb_addr),
        .wr_data_o    (wb_data)
    );

endmodule

`default_nettype wire

// File: testbench/proc_assertions.sv
`default_nettype none

module proc_assertions (
    input logic        clk_i,
    input logic        reset_i,
    input logic        ibus_cyc_i,
    input logic        ibus_stb_i,
    input logic [31:0] ibus_adr_i,
    input logic        ibus_ack_i,
    input logic        dbus_cyc_i,
    input logic        dbus_stb_i,
    input logic        dbus_we_i,
    input logic [31:0] dbus_adr_i,
    input logic        dbus_ack_i
);
    int assert_failures = 0;

    //////////////////////////////////////////////////
    // Instruction bus, Wishbone classic
    //////////////////////////////////////////////////
    ibus_stb_has_cyc: assert property (@(posedge clk_i) disable iff (reset_i)
        ibus_stb_i |-> ibus_cyc_i)
        else begin
            assert_failures++;
            $error("ibus stb high without cyc");
        end

    // Address held until ack
    ibus_adr_stable: assert property (@(posedge clk_i) disable iff (reset_i)
        ibus_stb_i && !ibus_ack_i |=> $stable(ibus_adr_i))
        else begin
            assert_failures++;
            $error("ibus address changed before ack");
        end

    //////////////////////////////////////////////////
    // Data bus, Wishbone classic writes only
    //////////////////////////////////////////////////
    dbus_stb_has_cyc: assert property (@(posedge clk_i) disable iff (reset_i)
        dbus_stb_i |-> dbus_cyc_i)
        else begin
            assert_failures++;
            $error("dbus stb high without cyc");
        end

    dbus_adr_stable: assert property (@(posedge clk_i) disable iff (reset_i)
        dbus_stb_i && !dbus_ack_i |=> $stable(dbus_adr_i))
        else begin
            assert_failures++;
            $error("dbus address changed before ack");
        end

    dbus_write_only: assert property (@(posedge clk_i) disable iff (reset_i)
        dbus_stb_i |-> dbus_we_i)
        else begin
            assert_failures++;
            $error("dbus stb high without we");
        end

endmodule

`default_nettype wire

// File: testbench/tb_proc.sv
`default_nettype none

module tb_proc import proc_pkg::*; ();

    localparam int          PROG_LEN       = 64;
    localparam int          RESET_CYCLES   = 10;
    localparam int          DRAIN_CYCLES   = 50;
    localparam int          TIMEOUT_CYCLES = RESET_CYCLES + PROG_LEN * 40 + DRAIN_CYCLES;
    localparam logic [31:0] LFSR_SEED      = 32'heb7b_b378;

    logic            clk_i = 1'b0;
    logic            reset_i;
    logic            ibus_cyc_o;
    logic            ibus_stb_o;
    logic [XLEN-1:0] ibus_adr_o;
    logic [XLEN-1:0] ibus_dat_i = '0;
    logic            ibus_ack_i = 1'b0;
    logic            dbus_cyc_o;
    logic            dbus_stb_o;
    logic            dbus_we_o;
    logic [XLEN-1:0] dbus_adr_o;
    logic [XLEN-1:0] dbus_dat_o;
    logic            dbus_ack_i = 1'b0;

    insn_u           program_mem [PROG_LEN];
    logic [XLEN-1:0] exp_addr [$];
    logic [XLEN-1:0] exp_data [$];
    int              exp_count   = 0;
    int              store_count = 0;
    logic [31:0]     prog_lfsr;
    logic [31:0]     ibus_lfsr;
    logic [31:0]     dbus_lfsr;
    logic [XLEN-1:0] fetch_pc;
    logic            ibus_busy;
    logic [1:0]      ibus_wait;
    logic            dbus_busy;
    logic [1:0]      dbus_wait;

    proc_top UUT (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .ibus_cyc_o (ibus_cyc_o),
        .ibus_stb_o (ibus_stb_o),
        .ibus_adr_o (ibus_adr_o),
        .ibus_dat_i (ibus_dat_i),
        .ibus_ack_i (ibus_ack_i),
        .dbus_cyc_o (dbus_cyc_o),
        .dbus_stb_o (dbus_stb_o),
        .dbus_we_o  (dbus_we_o),
        .dbus_adr_o (dbus_adr_o),
        .dbus_dat_o (dbus_dat_o),
        .dbus_ack_i (dbus_ack_i)
    );

    bind proc_top proc_assertions u_bus_checks (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .ibus_cyc_i (ibus_cyc_o),
        .ibus_stb_i (ibus_stb_o),
        .ibus_adr_i (ibus_adr_o),
        .ibus_ack_i (ibus_ack_i),
        .dbus_cyc_i (dbus_cyc_o),
        .dbus_stb_i (dbus_stb_o),
        .dbus_we_i  (dbus_we_o),
        .dbus_adr_i (dbus_adr_o),
        .dbus_ack_i (dbus_ack_i)
    );

    always #5 clk_i = ~clk_i;

    //////////////////////////////////////////////////
    // Random source and error handling
    //////////////////////////////////////////////////
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] take_bits(inout logic [31:0] state, input int n);
        logic [31:0] value;
        value = '0;
        for (int k = 0; k < n; k++) begin
            value = {value[30:0], state[0]};
            state = lfsr_step(state);
        end
        return value;
    endfunction

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic compare_addr(input string name, input logic [XLEN-1:0] expected,
                                input logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            stop_on_error($sformatf("mismatch %s: expected %h, actual %h",
                                    name, expected, actual));
        end
    endtask

    task automatic compare_data(input string name, input logic [XLEN-1:0] expected,
                                input logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            stop_on_error($sformatf("mismatch %s: expected %h, actual %h",
                                    name, expected, actual));
        end
    endtask

    //////////////////////////////////////////////////
    // Program and reference model
    //////////////////////////////////////////////////
    task automatic generate_program();
        insn_u             w;
        logic [REG_AW-1:0] prev_rd;
        logic [2:0]        pick;
        prev_rd = '0;
        for (int n = 0; n < PROG_LEN; n++) begin
            w       = '0;
            w.r.rd  = REG_AW'(take_bits(prog_lfsr, REG_AW));
            w.r.rs1 = REG_AW'(take_bits(prog_lfsr, REG_AW));
            // Chain on the previous result about half the time
            if (take_bits(prog_lfsr, 1) == 32'd1) begin
                w.r.rs1 = prev_rd;
            end
            if (n % 4 == 3) begin
                w.i.opcode = OP_STORE;
                w.i.imm    = IMM_W'(take_bits(prog_lfsr, 4));
            end else begin
                pick = 3'(take_bits(prog_lfsr, 3));
                case (pick)
                    3'd0:    w.r.opcode = OP_ADD;
                    3'd1:    w.r.opcode = OP_SUB;
                    3'd2:    w.r.opcode = OP_AND;
                    3'd3:    w.r.opcode = OP_OR;
                    3'd4:    w.r.opcode = OP_XOR;
                    default: w.r.opcode = OP_ADDI;
                endcase
                if (w.r.opcode == OP_ADDI) begin
                    w.i.imm = IMM_W'(take_bits(prog_lfsr, IMM_W));
                end else begin
                    w.r.rs2 = REG_AW'(take_bits(prog_lfsr, REG_AW));
                end
                prev_rd = w.r.rd;
            end
            program_mem[n] = w;
        end
        // Instruction 0 writes r0 and instruction 3 stores it
        program_mem[0].i.opcode = OP_ADDI;
        program_mem[0].i.rd     = '0;
        program_mem[0].i.imm    = 16'h1234;
        program_mem[3].i.rd     = '0;
    endtask

    function automatic void compute_expected_stores();
        logic [XLEN-1:0] regs [NUM_REGS];
        insn_u           w;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] res;
        for (int r = 0; r < NUM_REGS; r++) begin
            regs[r] = '0;
        end
        for (int n = 0; n < PROG_LEN; n++) begin
            w   = program_mem[n];
            a   = regs[w.r.rs1];
            b   = regs[w.r.rs2];
            imm = {{(XLEN-IMM_W){w.i.imm[IMM_W-1]}}, w.i.imm};
            res = '0;
            case (w.r.opcode)
                OP_ADD:  res = a + b;
                OP_SUB:  res = a - b;
                OP_AND:  res = a & b;
                OP_OR:   res = a | b;
                OP_XOR:  res = a ^ b;
                OP_ADDI: res = a + imm;
                OP_STORE: begin
                    exp_addr.push_back(a + imm);
                    exp_data.push_back(regs[w.i.rd]);
                end
                default: res = '0;
            endcase
            // r0 stays zero
            if (w.r.opcode inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI}
                && w.r.rd != '0) begin
                regs[w.r.rd] = res;
            end
        end
    endfunction

    // Past the program end the memory returns NOP
    function automatic logic [XLEN-1:0] read_program(input logic [XLEN-1:0] adr);
        int unsigned index;
        index = adr / PC_STEP;
        if (index < PROG_LEN) begin
            return program_mem[index];
        end
        return '0;
    endfunction

    //////////////////////////////////////////////////
    // Bus slaves
    //////////////////////////////////////////////////
    always @(posedge clk_i) begin
        if (reset_i) begin
            ibus_ack_i <= 1'b0;
            ibus_busy  <= 1'b0;
            ibus_wait  <= '0;
            fetch_pc   <= '0;
        end else if (ibus_ack_i) begin
            ibus_ack_i <= 1'b0;
            ibus_busy  <= 1'b0;
        end else if (ibus_stb_o && !ibus_busy) begin
            compare_addr("fetch address", fetch_pc, ibus_adr_o);
            fetch_pc  <= fetch_pc + PC_STEP;
            ibus_busy <= 1'b1;
            ibus_wait <= 2'(take_bits(ibus_lfsr, 2));
        end else if (ibus_busy) begin
            if (ibus_wait == '0) begin
                ibus_ack_i <= 1'b1;
                ibus_dat_i <= read_program(ibus_adr_o);
            end else begin
                ibus_wait <= ibus_wait - 2'd1;
            end
        end
    end

    always @(posedge clk_i) begin
        if (reset_i) begin
            dbus_ack_i <= 1'b0;
            dbus_busy  <= 1'b0;
            dbus_wait  <= '0;
        end else if (dbus_ack_i) begin
            dbus_ack_i <= 1'b0;
            dbus_busy  <= 1'b0;
        end else if (dbus_stb_o && !dbus_busy) begin
            dbus_busy <= 1'b1;
            dbus_wait <= 2'(take_bits(dbus_lfsr, 2));
        end else if (dbus_busy) begin
            if (dbus_wait == '0) begin
                dbus_ack_i <= 1'b1;
            end else begin
                dbus_wait <= dbus_wait - 2'd1;
            end
        end
    end

    // Each store is checked in the cycle its ack is sampled
    always @(posedge clk_i) begin
        if (!reset_i && dbus_stb_o && dbus_ack_i) begin
            if (store_count >= exp_count) begin
                stop_on_error("data bus write after all expected stores were done");
            end else begin
                compare_addr($sformatf("store %0d address", store_count),
                             exp_addr[store_count], dbus_adr_o);
                compare_data($sformatf("store %0d data", store_count),
                             exp_data[store_count], dbus_dat_o);
                store_count <= store_count + 1;
            end
        end
    end

    always @(posedge clk_i) begin
        if (UUT.u_bus_checks.assert_failures != 0) begin
            stop_on_error("a bus protocol assertion failed");
        end
    end

    //////////////////////////////////////////////////
    // Main sequence and watchdog
    //////////////////////////////////////////////////
    initial begin
        reset_i   = 1'b1;
        prog_lfsr = LFSR_SEED;
        generate_program();
        ibus_lfsr = prog_lfsr;
        dbus_lfsr = take_bits(prog_lfsr, 32);
        compute_expected_stores();
        exp_count = exp_addr.size();
        repeat (RESET_CYCLES) @(posedge clk_i);
        if (ibus_cyc_o !== 1'b0 || dbus_cyc_o !== 1'b0) begin
            stop_on_error("a bus cycle is active while reset is held");
        end
        reset_i <= 1'b0;
        wait (store_count == exp_count);
        // Extra stores would show up here
        repeat (DRAIN_CYCLES) @(posedge clk_i);
        $display("Everything OK");
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk_i);
        stop_on_error("timeout, the program did not complete its stores in time");
    end

endmodule

`default_nettype wire

// File: all.f
common/proc_pkg.sv
design/pipe_buffer.sv
design/register_file.sv
fetch/fetch_unit.sv
decode/decode_stage.sv
execute/execute_stage.sv
commit/commit_stage.sv
design/proc_top.sv
testbench/proc_assertions.sv
testbench/tb_proc.sv
